//--- rtl/isa_pkg.sv
package isa_pkg;

  // --------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------

  // Data word or program counter
  typedef logic [31:0] xlen_t;
  // Raw instruction word
  typedef logic [31:0] inst_t;
  // Architectural register index
  typedef logic [4:0]  reg_idx_t;

  // Distance to the next sequential instruction
  localparam xlen_t PC_STEP = 32'd4;

  // --------------------------------------------------------------------
  // Major opcodes
  // --------------------------------------------------------------------

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // --------------------------------------------------------------------
  // Function codes
  // --------------------------------------------------------------------

  localparam logic [2:0] F3_ANDI = 3'b111;
  localparam logic [2:0] F3_LBU  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;

  // --------------------------------------------------------------------
  // Error report
  // --------------------------------------------------------------------

  typedef logic [1:0] err_kind_t;

  localparam err_kind_t ERR_NONE   = 2'd0;
  // Wrong writeback or load address
  localparam err_kind_t ERR_RESULT = 2'd1;
  // Commit at an unexpected PC
  localparam err_kind_t ERR_FLOW   = 2'd2;

endpackage

//--- rtl/verdict_if.sv
`timescale 1ns/1ps

// Per-cycle verdict from one checker to the collector
interface verdict_if import isa_pkg::*; ();

  // One-cycle pulse per failing commit
  logic      fail;
  // Payload, valid only with fail
  err_kind_t kind;
  xlen_t     pc;
  inst_t     inst;

  modport src (
    output fail, kind, pc, inst
  );

  modport dst (
    input fail, kind, pc, inst
  );

endinterface

//--- rtl/shadow_regfile.sv
`timescale 1ns/1ps

module shadow_regfile import isa_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     commit_valid_i,
  input  inst_t    commit_inst_i,
  input  logic     commit_we_i,
  input  reg_idx_t commit_rd_i,
  input  xlen_t    commit_value_i,
  output xlen_t    rs1_val_o,
  output xlen_t    rs2_val_o
);

  // x0 has no storage
  xlen_t    regs [1:31];
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  logic     wr_en;

  assign rs1_idx = commit_inst_i[19:15];
  assign rs2_idx = commit_inst_i[24:20];

  // Reads see the state before this cycle's write
  assign rs1_val_o = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_val_o = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  assign wr_en = commit_valid_i && commit_we_i && (commit_rd_i != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[commit_rd_i] <= commit_value_i;
    end
  end

endmodule

//--- rtl/result_checker.sv
`timescale 1ns/1ps

module result_checker import isa_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     commit_valid_i,
  input  xlen_t    commit_pc_i,
  input  inst_t    commit_inst_i,
  input  logic     commit_we_i,
  input  reg_idx_t commit_rd_i,
  input  xlen_t    commit_value_i,
  input  xlen_t    commit_mem_addr_i,
  input  xlen_t    commit_mem_data_i,
  input  xlen_t    rs1_val_i,
  verdict_if.src   vd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rd_field;
  xlen_t      imm_i;
  xlen_t      imm_u;
  logic       is_andi;
  logic       is_auipc;
  logic       is_lbu;
  logic       is_jal;
  xlen_t      load_addr;
  logic [7:0] load_byte;
  xlen_t      golden_value;
  logic       mismatch;

  // --------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------

  assign opcode   = commit_inst_i[6:0];
  assign funct3   = commit_inst_i[14:12];
  assign rd_field = commit_inst_i[11:7];

  assign imm_i = {{20{commit_inst_i[31]}}, commit_inst_i[31:20]};
  assign imm_u = {commit_inst_i[31:12], 12'b0};

  assign is_andi  = (opcode == OPC_OP_IMM) && (funct3 == F3_ANDI);
  assign is_auipc = (opcode == OPC_AUIPC);
  assign is_lbu   = (opcode == OPC_LOAD) && (funct3 == F3_LBU);
  assign is_jal   = (opcode == OPC_JAL);

  // --------------------------------------------------------------------
  // Golden results
  // --------------------------------------------------------------------

  assign load_addr = rs1_val_i + imm_i;
  // Byte lane picked by the low address bits
  assign load_byte = commit_mem_data_i[{load_addr[1:0], 3'b000} +: 8];

  always_comb begin
    golden_value = '0;
    if (is_andi) golden_value = rs1_val_i & imm_i;
    if (is_auipc) golden_value = commit_pc_i + imm_u;
    if (is_lbu) golden_value = {24'b0, load_byte};
    if (is_jal) golden_value = commit_pc_i + PC_STEP;
  end

  assign mismatch = (commit_we_i != (rd_field != '0))
                 || (commit_rd_i != rd_field)
                 || (commit_value_i != golden_value)
                 || (is_lbu && (commit_mem_addr_i != load_addr));

  // --------------------------------------------------------------------
  // Verdict register
  // --------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vd.fail <= 1'b0;
    end else begin
      vd.fail <= commit_valid_i && (is_andi || is_auipc || is_lbu || is_jal) && mismatch;
    end
  end

  always_ff @(posedge clk) begin
    vd.kind <= ERR_RESULT;
    vd.pc   <= commit_pc_i;
    vd.inst <= commit_inst_i;
  end

endmodule

//--- rtl/flow_checker.sv
`timescale 1ns/1ps

module flow_checker import isa_pkg::*; #(
  parameter xlen_t RESET_PC = 32'h200
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   commit_valid_i,
  input  xlen_t  commit_pc_i,
  input  inst_t  commit_inst_i,
  input  xlen_t  rs1_val_i,
  input  xlen_t  rs2_val_i,
  verdict_if.src vd
);

  typedef enum logic [1:0] {
    FLOW_RESET,
    FLOW_TRACK,
    FLOW_FREE
  } flow_state_e;

  flow_state_e state_q;
  flow_state_e state_d;
  xlen_t       expect_pc_q;
  xlen_t       next_pc;
  logic [6:0]  opcode;
  logic        is_bge;
  logic        bge_taken;
  xlen_t       imm_j;
  xlen_t       imm_b;
  logic        pc_bad;

  assign opcode = commit_inst_i[6:0];
  assign is_bge = (opcode == OPC_BRANCH) && (commit_inst_i[14:12] == F3_BGE);

  assign imm_j = {{12{commit_inst_i[31]}}, commit_inst_i[19:12], commit_inst_i[20],
                  commit_inst_i[30:21], 1'b0};
  assign imm_b = {{20{commit_inst_i[31]}}, commit_inst_i[7], commit_inst_i[30:25],
                  commit_inst_i[11:8], 1'b0};

  assign bge_taken = $signed(rs1_val_i) >= $signed(rs2_val_i);

  // Expectation check against the current state
  always_comb begin
    case (state_q)
      FLOW_RESET: pc_bad = (commit_pc_i != RESET_PC);
      FLOW_TRACK: pc_bad = (commit_pc_i != expect_pc_q);
      default:    pc_bad = 1'b0;
    endcase
  end

  // Next expected PC after this commit
  always_comb begin
    next_pc = commit_pc_i + PC_STEP;
    state_d = FLOW_TRACK;
    if (opcode == OPC_JAL) begin
      next_pc = (commit_pc_i + imm_j) & ~32'h3;
    end else if (is_bge && bge_taken) begin
      next_pc = commit_pc_i + imm_b;
    end else if (opcode == OPC_JALR) begin
      state_d = FLOW_FREE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FLOW_RESET;
      vd.fail <= 1'b0;
    end else begin
      vd.fail <= commit_valid_i && pc_bad;
      // Bubbles hold the expectation
      if (commit_valid_i) state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_valid_i) begin
      expect_pc_q <= next_pc;
    end
    vd.kind <= ERR_FLOW;
    vd.pc   <= commit_pc_i;
    vd.inst <= commit_inst_i;
  end

endmodule

//--- rtl/verdict_collector.sv
`timescale 1ns/1ps

module verdict_collector import isa_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  verdict_if.dst    res_vd,
  verdict_if.dst    flow_vd,
  output logic      error_o,
  output err_kind_t err_kind_o,
  output xlen_t     err_pc_o,
  output inst_t     err_inst_o
);

  logic new_fail;

  // Only the first failure after reset is recorded
  assign new_fail = !error_o && (res_vd.fail || flow_vd.fail);

  // --------------------------------------------------------------------
  // Sticky first-error report
  // --------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_o    <= 1'b0;
      err_kind_o <= ERR_NONE;
      err_pc_o   <= '0;
      err_inst_o <= '0;
    end else if (new_fail) begin
      error_o <= 1'b1;
      // Result verdict takes priority on a tie
      if (res_vd.fail) begin
        err_kind_o <= res_vd.kind;
        err_pc_o   <= res_vd.pc;
        err_inst_o <= res_vd.inst;
      end else begin
        err_kind_o <= flow_vd.kind;
        err_pc_o   <= flow_vd.pc;
        err_inst_o <= flow_vd.inst;
      end
    end
  end

endmodule

//--- rtl/commit_checker_top.sv
`timescale 1ns/1ps

module commit_checker_top import isa_pkg::*; #(
  parameter xlen_t RESET_PC = 32'h200
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      commit_valid_i,
  input  xlen_t     commit_pc_i,
  input  inst_t     commit_inst_i,
  input  logic      commit_we_i,
  input  reg_idx_t  commit_rd_i,
  input  xlen_t     commit_value_i,
  input  xlen_t     commit_mem_addr_i,
  input  xlen_t     commit_mem_data_i,
  output logic      error_o,
  output err_kind_t err_kind_o,
  output xlen_t     err_pc_o,
  output inst_t     err_inst_o
);

  xlen_t rs1_val;
  xlen_t rs2_val;

  verdict_if res_vd ();
  verdict_if flow_vd ();

  // Architectural state rebuilt from commits
  shadow_regfile shadow_regfile_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .commit_valid_i (commit_valid_i),
    .commit_inst_i  (commit_inst_i),
    .commit_we_i    (commit_we_i),
    .commit_rd_i    (commit_rd_i),
    .commit_value_i (commit_value_i),
    .rs1_val_o      (rs1_val),
    .rs2_val_o      (rs2_val)
  );

  result_checker result_checker_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .commit_valid_i    (commit_valid_i),
    .commit_pc_i       (commit_pc_i),
    .commit_inst_i     (commit_inst_i),
    .commit_we_i       (commit_we_i),
    .commit_rd_i       (commit_rd_i),
    .commit_value_i    (commit_value_i),
    .commit_mem_addr_i (commit_mem_addr_i),
    .commit_mem_data_i (commit_mem_data_i),
    .rs1_val_i         (rs1_val),
    .vd                (res_vd)
  );

  flow_checker #(
    .RESET_PC (RESET_PC)
  ) flow_checker_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .commit_valid_i (commit_valid_i),
    .commit_pc_i    (commit_pc_i),
    .commit_inst_i  (commit_inst_i),
    .rs1_val_i      (rs1_val),
    .rs2_val_i      (rs2_val),
    .vd             (flow_vd)
  );

  verdict_collector verdict_collector_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_vd     (res_vd),
    .flow_vd    (flow_vd),
    .error_o    (error_o),
    .err_kind_o (err_kind_o),
    .err_pc_o   (err_pc_o),
    .err_inst_o (err_inst_o)
  );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 4
) (
  input  logic reset_req_i,
  output logic clk,
  output logic rst_n
);

  // Rising edges seen since the last reset request
  int low_cnt = 0;

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  always @(posedge clk) begin
    if (reset_req_i) begin
      low_cnt <= 0;
    end else if (low_cnt < RESET_CYCLES) begin
      low_cnt <= low_cnt + 1;
    end
  end

  assign rst_n = (low_cnt >= RESET_CYCLES);

endmodule

//--- verification/tb_commit_checker.sv
`timescale 1ns/1ps

module tb_commit_checker import isa_pkg::*; ();

  localparam xlen_t RESET_PC       = 32'h200;
  localparam int    RANDOM_COMMITS = 300;
  // Well above the length of all scenarios together
  localparam int    TIMEOUT_CYCLES = 4000;

  localparam int FAULT_NONE  = 0;
  localparam int FAULT_VALUE = 1;
  localparam int FAULT_ADDR  = 2;
  localparam int FAULT_WE    = 3;

  logic      clk;
  logic      rst_n;
  logic      reset_req;
  logic      c_valid;
  xlen_t     c_pc;
  inst_t     c_inst;
  logic      c_we;
  reg_idx_t  c_rd;
  xlen_t     c_value;
  xlen_t     c_addr;
  xlen_t     c_data;
  logic      error;
  err_kind_t err_kind;
  xlen_t     err_pc;
  inst_t     err_inst;

  // Reference state
  xlen_t       ref_regs [32];
  xlen_t       ref_next_pc;
  logic [31:0] rng_state;
  int          cycle_cnt = 0;

  // Predicted verdict of the commit on the bus, then one stage later
  logic      pend_fail;
  err_kind_t pend_kind;
  xlen_t     pend_pc;
  inst_t     pend_inst;
  logic      vd_fail;
  err_kind_t vd_kind;
  xlen_t     vd_pc;
  inst_t     vd_inst;
  // Expected sticky report
  logic      rep_err;
  err_kind_t rep_kind;
  xlen_t     rep_pc;
  inst_t     rep_inst;

  tb_clk_gen tb_clk_gen_inst (
    .reset_req_i (reset_req),
    .clk         (clk),
    .rst_n       (rst_n)
  );

  commit_checker_top #(
    .RESET_PC (RESET_PC)
  ) commit_checker_top_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .commit_valid_i    (c_valid),
    .commit_pc_i       (c_pc),
    .commit_inst_i     (c_inst),
    .commit_we_i       (c_we),
    .commit_rd_i       (c_rd),
    .commit_value_i    (c_value),
    .commit_mem_addr_i (c_addr),
    .commit_mem_data_i (c_data),
    .error_o           (error),
    .err_kind_o        (err_kind),
    .err_pc_o          (err_pc),
    .err_inst_o        (err_inst)
  );

  // ------------------------------------------------------------------
  // Random numbers and instruction encoders
  // ------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic inst_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                  input reg_idx_t rd, input reg_idx_t rs1,
                                  input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_u(input logic [6:0] opc, input reg_idx_t rd,
                                  input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic inst_t enc_j(input reg_idx_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic inst_t enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                  input reg_idx_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------

  function automatic void ref_reset();
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    ref_next_pc = RESET_PC;
  endfunction

  // Correct commit for one instruction; unchecked ones get a random value
  function automatic void ref_commit(input xlen_t pc, input inst_t inst, input xlen_t data,
                                     output logic we, output reg_idx_t rd,
                                     output xlen_t value, output xlen_t addr);
    xlen_t rs1;
    xlen_t imm_i;
    rs1   = ref_regs[inst[19:15]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    rd    = inst[11:7];
    we    = (rd != '0);
    value = next_rand();
    addr  = rs1 + imm_i;
    case (inst[6:0])
      OPC_OP_IMM: if (inst[14:12] == F3_ANDI) value = rs1 & imm_i;
      OPC_AUIPC:  value = pc + {inst[31:12], 12'h000};
      OPC_LOAD:   value = (data >> {addr[1:0], 3'b000}) & 32'hff;
      OPC_JAL:    value = pc + PC_STEP;
      OPC_BRANCH: begin
        we    = 1'b0;
        rd    = '0;
        value = '0;
      end
      default: ;
    endcase
  endfunction

  function automatic logic is_checked(input inst_t inst);
    return ((inst[6:0] == OPC_OP_IMM) && (inst[14:12] == F3_ANDI))
        || (inst[6:0] == OPC_AUIPC)
        || ((inst[6:0] == OPC_LOAD) && (inst[14:12] == F3_LBU))
        || (inst[6:0] == OPC_JAL);
  endfunction

  // Next expected PC, using register values before this commit's write
  function automatic xlen_t ref_next(input xlen_t pc, input inst_t inst);
    xlen_t imm_j;
    xlen_t imm_b;
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    if (inst[6:0] == OPC_JAL) return (pc + imm_j) & ~32'h3;
    if ((inst[6:0] == OPC_BRANCH) && (inst[14:12] == F3_BGE)
        && ($signed(ref_regs[inst[19:15]]) >= $signed(ref_regs[inst[24:20]]))) begin
      return pc + imm_b;
    end
    return pc + PC_STEP;
  endfunction

  // Sticky report, 2 cycles behind the commit
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vd_fail  <= 1'b0;
      vd_kind  <= ERR_NONE;
      vd_pc    <= '0;
      vd_inst  <= '0;
      rep_err  <= 1'b0;
      rep_kind <= ERR_NONE;
      rep_pc   <= '0;
      rep_inst <= '0;
    end else begin
      vd_fail <= pend_fail;
      vd_kind <= pend_kind;
      vd_pc   <= pend_pc;
      vd_inst <= pend_inst;
      if (!rep_err && vd_fail) begin
        rep_err  <= 1'b1;
        rep_kind <= vd_kind;
        rep_pc   <= vd_pc;
        rep_inst <= vd_inst;
      end
    end
  end

  // ------------------------------------------------------------------
  // Checking and run control
  // ------------------------------------------------------------------

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("test failed");
      $fatal(1, "stopping at the first wrong value");
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      check("error_o", 32'(error), 32'(rep_err));
      check("err_kind_o", 32'(err_kind), 32'(rep_kind));
      check("err_pc_o", err_pc, rep_pc);
      check("err_inst_o", err_inst, rep_inst);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("test failed");
      $fatal(1, "the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  task automatic drive(input logic valid, input xlen_t pc, input inst_t inst,
                       input logic we, input reg_idx_t rd, input xlen_t value,
                       input xlen_t addr, input xlen_t data,
                       input logic res_fail, input logic flow_fail);
    @(posedge clk);
    c_valid   <= valid;
    c_pc      <= pc;
    c_inst    <= inst;
    c_we      <= we;
    c_rd      <= rd;
    c_value   <= value;
    c_addr    <= addr;
    c_data    <= data;
    pend_fail <= res_fail || flow_fail;
    pend_kind <= res_fail ? ERR_RESULT : ERR_FLOW;
    pend_pc   <= pc;
    pend_inst <= inst;
  endtask

  // Bubble with random fields that must be ignored
  task automatic bubble();
    logic [31:0] r;
    r = next_rand();
    drive(1'b0, r, next_rand(), 1'b1, r[11:7], next_rand(), r, next_rand(), 1'b0, 1'b0);
  endtask

  task automatic send(input xlen_t pc, input inst_t inst, input int fault);
    logic     g_we;
    logic     we;
    reg_idx_t g_rd;
    xlen_t    g_value;
    xlen_t    value;
    xlen_t    g_addr;
    xlen_t    addr;
    xlen_t    data;
    logic     is_lbu;
    logic     res_fail;
    logic     flow_fail;
    data = next_rand();
    ref_commit(pc, inst, data, g_we, g_rd, g_value, g_addr);
    we    = g_we;
    value = g_value;
    addr  = g_addr;
    case (fault)
      FAULT_VALUE: value = value ^ 32'h1;
      FAULT_ADDR:  addr = addr ^ 32'h4;
      FAULT_WE:    we = 1'b1;
      default: ;
    endcase
    is_lbu    = (inst[6:0] == OPC_LOAD) && (inst[14:12] == F3_LBU);
    res_fail  = is_checked(inst) && ((we != g_we) || (value != g_value)
                                     || (is_lbu && (addr != g_addr)));
    flow_fail = (pc != ref_next_pc);
    ref_next_pc = ref_next(pc, inst);
    if (we && (g_rd != '0)) ref_regs[g_rd] = value;
    drive(1'b1, pc, inst, we, g_rd, value, addr, data, res_fail, flow_fail);
  endtask

  task automatic restart();
    bubble();
    @(posedge clk);
    reset_req <= 1'b1;
    @(posedge clk);
    reset_req <= 1'b0;
    @(posedge clk);
    while (!rst_n) @(posedge clk);
    ref_reset();
  endtask

  task automatic expect_report(input err_kind_t kind, input xlen_t pc, input inst_t inst);
    repeat (3) bubble();
    @(negedge clk);
    check("error_o", 32'(error), 32'(kind != ERR_NONE));
    check("err_kind_o", 32'(err_kind), 32'(kind));
    check("err_pc_o", err_pc, pc);
    check("err_inst_o", err_inst, inst);
  endtask

  task automatic random_stream(input int count);
    logic [31:0] r;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    inst_t       inst;
    int          sent;
    sent = 0;
    while (sent < count) begin
      r    = next_rand();
      rd   = r[12:8];
      rs1  = r[17:13];
      rs2  = r[22:18];
      inst = '0;
      case (r[2:0])
        3'd0: inst = enc_i(OPC_OP_IMM, F3_ANDI, rd, rs1, r[31:20]);
        3'd1: inst = enc_u(OPC_AUIPC, rd, r[31:12]);
        3'd2: inst = enc_i(OPC_LOAD, F3_LBU, rd, rs1, r[31:20]);
        3'd3: inst = enc_j(rd, {{11{r[31]}}, r[27:20], 2'b00});
        3'd4: inst = enc_b(F3_BGE, rs1, rs2, {{4{r[31]}}, r[26:20], 2'b00});
        // addi and ori
        3'd5: inst = enc_i(OPC_OP_IMM, 3'b000, rd, rs1, r[31:20]);
        3'd6: inst = enc_i(OPC_OP_IMM, 3'b110, rd, rs1, r[31:20]);
        default: ;
      endcase
      if (r[2:0] == 3'd7) begin
        bubble();
      end else begin
        send(ref_next_pc, inst, FAULT_NONE);
        sent++;
      end
    end
  endtask

  initial begin
    xlen_t bad_pc;
    inst_t bad_inst;
    xlen_t bge_pc;
    c_valid   <= 1'b0;
    c_pc      <= '0;
    c_inst    <= '0;
    c_we      <= 1'b0;
    c_rd      <= '0;
    c_value   <= '0;
    c_addr    <= '0;
    c_data    <= '0;
    pend_fail <= 1'b0;
    pend_kind <= ERR_NONE;
    pend_pc   <= '0;
    pend_inst <= '0;
    reset_req <= 1'b0;
    rng_state = 32'he2a3f1ac;
    ref_reset();
    @(posedge clk);
    while (!rst_n) @(posedge clk);

    // Correct random stream
    random_stream(RANDOM_COMMITS);
    expect_report(ERR_NONE, '0, '0);

    // Corrupted andi, then a second error that must not overwrite the report
    restart();
    send(ref_next_pc, enc_u(OPC_AUIPC, 5'd2, 20'h12345), FAULT_NONE);
    bad_pc   = ref_next_pc;
    bad_inst = enc_i(OPC_OP_IMM, F3_ANDI, 5'd4, 5'd2, 12'h0f0);
    send(bad_pc, bad_inst, FAULT_VALUE);
    bubble();
    send(ref_next_pc, enc_i(OPC_OP_IMM, F3_ANDI, 5'd5, 5'd4, 12'hf0f), FAULT_VALUE);
    expect_report(ERR_RESULT, bad_pc, bad_inst);

    // lbu on every byte lane, then a wrong load address
    restart();
    for (int k = 0; k < 4; k++) begin
      send(ref_next_pc, enc_i(OPC_LOAD, F3_LBU, 5'd6, 5'd0, 12'(64 + k)), FAULT_NONE);
    end
    expect_report(ERR_NONE, '0, '0);
    bad_pc   = ref_next_pc;
    bad_inst = enc_i(OPC_LOAD, F3_LBU, 5'd7, 5'd6, 12'h003);
    send(bad_pc, bad_inst, FAULT_ADDR);
    expect_report(ERR_RESULT, bad_pc, bad_inst);

    // Taken bge followed by the sequential address
    restart();
    bge_pc = ref_next_pc;
    send(bge_pc, enc_b(F3_BGE, 5'd0, 5'd0, 13'd16), FAULT_NONE);
    bubble();
    bubble();
    bad_inst = enc_i(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'h001);
    send(bge_pc + PC_STEP, bad_inst, FAULT_NONE);
    expect_report(ERR_FLOW, bge_pc + PC_STEP, bad_inst);

    // Not-taken bge, x1 negative
    restart();
    send(ref_next_pc, enc_u(OPC_AUIPC, 5'd1, 20'hfffff), FAULT_NONE);
    bge_pc = ref_next_pc;
    send(bge_pc, enc_b(F3_BGE, 5'd1, 5'd0, 13'd16), FAULT_NONE);
    bubble();
    bubble();
    send(bge_pc + PC_STEP, enc_i(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'h001), FAULT_NONE);
    expect_report(ERR_NONE, '0, '0);

    // First commit away from the reset address
    restart();
    bad_pc   = RESET_PC + PC_STEP;
    bad_inst = enc_i(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'h010);
    send(bad_pc, bad_inst, FAULT_NONE);
    expect_report(ERR_FLOW, bad_pc, bad_inst);

    // Write enable with rd zero on a checked instruction
    restart();
    bad_pc   = ref_next_pc;
    bad_inst = enc_i(OPC_OP_IMM, F3_ANDI, 5'd0, 5'd0, 12'hfff);
    send(bad_pc, bad_inst, FAULT_WE);
    expect_report(ERR_RESULT, bad_pc, bad_inst);

    // Write attempt to x0, then x0 must still read zero
    restart();
    send(ref_next_pc, enc_i(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'h7ff), FAULT_WE);
    send(ref_next_pc, enc_i(OPC_OP_IMM, F3_ANDI, 5'd5, 5'd0, 12'hfff), FAULT_NONE);
    send(ref_next_pc, enc_i(OPC_LOAD, F3_LBU, 5'd6, 5'd0, 12'h021), FAULT_NONE);
    expect_report(ERR_NONE, '0, '0);

    $display("test passed");
    $finish;
  end

endmodule

//--- list.f
rtl/isa_pkg.sv
rtl/verdict_if.sv
rtl/shadow_regfile.sv
rtl/result_checker.sv
rtl/flow_checker.sv
rtl/verdict_collector.sv
rtl/commit_checker_top.sv
verification/tb_clk_gen.sv
verification/tb_commit_checker.sv

//--- Makefile
# Verilator build and run for the commit-stream checker testbench

VERILATOR ?= verilator
TOP       ?= tb_commit_checker
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
JOBS      ?= 4

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The simulator exits with a failing status on $fatal
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
